// ==== capture_settings.svh ====
`ifndef CAPTURE_SETTINGS_SVH
`define CAPTURE_SETTINGS_SVH

// Source timing, one pixel per clock
`define H_TOTAL         858
`define V_TOTAL         525

// Capture window
`define CAPTURE_WIDTH   640
`define H_START_PROG    44
`define H_START_DBL     1
`define V_END_PROG      480

// In line-doubled mode each field holds 240 lines
`define FIELD_LINES     240
`define FIELD2_FIRST    263

// Readout trigger points
`define H_TRIGGER       320
`define V_TRIGGER_PROG  1
`define V_TRIGGER_F1    1
`define V_TRIGGER_F2    264

// Ring buffer geometry, four slots of 1024 pixels
`define BUFFER_LINES    4
`define LINE_SLOT       1024

// Bus widths
`define COORD_W         12
`define ADDR_W          12

`endif

// ==== capture_pkg.sv ====
package capture_pkg;

    // Scan mode of the source, constant over a frame
    typedef enum logic {
        mode_progressive,
        mode_line_doubled
    } scan_mode_t;

    // Line readout FSM
    typedef enum logic [1:0] {
        rd_idle,
        rd_wait_line,
        rd_read_line
    } reader_state_t;

endpackage

// ==== video_counters.sv ====
`timescale 1ns/100ps

`include "capture_settings.svh"

module video_counters (
    input  logic                clock,
    input  logic                reset,
    input  logic                line_start,
    input  logic                frame_start,
    input  logic [23:0]         pixel,
    output logic [`COORD_W-1:0] counter_x,
    output logic [`COORD_W-1:0] counter_y,
    output logic [23:0]         pixel_d
);

    // The pixel that arrives with line_start sits at column 0
    always_ff @(posedge clock) begin
        if (reset) begin
            counter_x <= '0;
        end else if (line_start) begin
            counter_x <= '0;
        end else if (counter_x != '1) begin
            counter_x <= counter_x + 1'b1;
        end
    end

    // Both counters hold at their maximum if the strobes stop
    always_ff @(posedge clock) begin
        if (reset) begin
            counter_y <= '0;
        end else if (frame_start) begin
            counter_y <= '0;
        end else if (line_start && counter_y != '1) begin
            counter_y <= counter_y + 1'b1;
        end
    end

    // One register stage keeps the pixel lined up with its coordinates
    always_ff @(posedge clock) begin
        pixel_d <= pixel;
    end

    // A frame always begins on a line boundary
    frame_on_line: assert property (
        @(posedge clock) disable iff (reset)
        frame_start |-> line_start
    );

endmodule

// ==== video2ram.sv ====
`timescale 1ns/100ps

`include "capture_settings.svh"

module video2ram
    import capture_pkg::*;
(
    input  logic                clock,
    input  logic                reset,
    input  scan_mode_t          scan_mode,
    input  logic [23:0]         pixel_d,
    input  logic [`COORD_W-1:0] counter_x,
    input  logic [`COORD_W-1:0] counter_y,
    output logic                wr_en,
    output logic [`ADDR_W-1:0]  wr_addr,
    output logic [23:0]         wr_data,
    output logic                start_trigger,
    output logic                start_field
);

    logic [`COORD_W-1:0] h_start;
    logic [`COORD_W-1:0] col;
    logic [`COORD_W-1:0] line_num;
    logic                in_lines;
    logic                in_window;
    logic                trigger_hit;
    logic                trigger_field;

    // Window and trigger points for the current scan mode
    always_comb begin
        h_start       = `COORD_W'(`H_START_PROG);
        line_num      = counter_y;
        in_lines      = counter_y < `COORD_W'(`V_END_PROG);
        trigger_hit   = counter_y == `COORD_W'(`V_TRIGGER_PROG);
        trigger_field = 1'b0;
        if (scan_mode == mode_line_doubled) begin
            h_start = `COORD_W'(`H_START_DBL);
            if (counter_y < `COORD_W'(`FIELD_LINES)) begin
                in_lines = 1'b1;
            end else if (counter_y >= `COORD_W'(`FIELD2_FIRST) &&
                         counter_y < `COORD_W'(`FIELD2_FIRST + `FIELD_LINES)) begin
                // Second field lines map back onto stored lines 0 to 239
                in_lines = 1'b1;
                line_num = counter_y - `COORD_W'(`FIELD2_FIRST);
            end else begin
                in_lines = 1'b0;
            end
            trigger_hit   = counter_y == `COORD_W'(`V_TRIGGER_F1) ||
                            counter_y == `COORD_W'(`V_TRIGGER_F2);
            trigger_field = counter_y == `COORD_W'(`V_TRIGGER_F2);
        end
    end

    assign col       = counter_x - h_start;
    assign in_window = in_lines && counter_x >= h_start &&
                       counter_x < h_start + `COORD_W'(`CAPTURE_WIDTH);

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_en         <= 1'b0;
            start_trigger <= 1'b0;
            start_field   <= 1'b0;
        end else begin
            wr_en <= in_window;
            if (trigger_hit && counter_x == `COORD_W'(`H_TRIGGER)) begin
                start_trigger <= 1'b1;
                start_field   <= trigger_field;
            end else begin
                start_trigger <= 1'b0;
                start_field   <= 1'b0;
            end
        end
    end

    // Stored line L lands in slot L mod 4
    always_ff @(posedge clock) begin
        wr_data <= pixel_d;
        wr_addr <= `ADDR_W'((line_num % `BUFFER_LINES) * `LINE_SLOT + col);
    end

    wr_column_in_range: assert property (
        @(posedge clock) disable iff (reset)
        wr_en |-> (wr_addr % `LINE_SLOT) < `CAPTURE_WIDTH
    );

    trigger_single_cycle: assert property (
        @(posedge clock) disable iff (reset)
        start_trigger |=> !start_trigger
    );

endmodule

// ==== line_buffer_ram.sv ====
`timescale 1ns/100ps

`include "capture_settings.svh"

module line_buffer_ram (
    input  logic               clock,
    input  logic               wr_en,
    input  logic [`ADDR_W-1:0] wr_addr,
    input  logic [23:0]        wr_data,
    input  logic               rd_en,
    input  logic [`ADDR_W-1:0] rd_addr,
    output logic [23:0]        rd_data
);

    // Four line slots of 1024 pixels each
    logic [23:0] mem [0:(1 << `ADDR_W)-1];

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, data follows rd_en by one clock
    always_ff @(posedge clock) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== line_reader.sv ====
`timescale 1ns/100ps

`include "capture_settings.svh"

module line_reader
    import capture_pkg::*;
(
    input  logic               clock,
    input  logic               reset,
    input  scan_mode_t         scan_mode,
    input  logic               start_trigger,
    input  logic               start_field,
    input  logic [23:0]        rd_data,
    output logic               rd_en,
    output logic [`ADDR_W-1:0] rd_addr,
    output logic               out_valid,
    output logic [23:0]        out_pixel,
    output logic [9:0]         out_x,
    output logic [8:0]         out_line,
    output logic               out_field
);

    localparam logic [9:0] last_read   = 10'(`CAPTURE_WIDTH - 1);
    localparam logic [9:0] last_period = 10'(`H_TOTAL - 1);

    reader_state_t state;
    logic [9:0]    period_count;
    logic [8:0]    line_count;
    logic [8:0]    last_line;
    logic          field;

    logic          tag_valid;
    logic [9:0]    tag_x;
    logic [8:0]    tag_line;
    logic          tag_field;

    // Each run line takes exactly one source line period,
    // period_count doubles as the pixel index while reading
    always_ff @(posedge clock) begin
        if (reset) begin
            state        <= rd_idle;
            rd_en        <= 1'b0;
            period_count <= '0;
            line_count   <= '0;
        end else if (start_trigger) begin
            state        <= rd_read_line;
            rd_en        <= 1'b1;
            period_count <= '0;
            line_count   <= '0;
        end else begin
            case (state)
                rd_read_line: begin
                    period_count <= period_count + 1'b1;
                    if (period_count == last_read) begin
                        state <= rd_wait_line;
                        rd_en <= 1'b0;
                    end
                end
                rd_wait_line: begin
                    if (period_count == last_period) begin
                        period_count <= '0;
                        if (line_count == last_line) begin
                            state <= rd_idle;
                        end else begin
                            state      <= rd_read_line;
                            rd_en      <= 1'b1;
                            line_count <= line_count + 1'b1;
                        end
                    end else begin
                        period_count <= period_count + 1'b1;
                    end
                end
                default: begin
                    rd_en <= 1'b0;
                end
            endcase
        end
    end

    // Run length and field are taken from the trigger
    always_ff @(posedge clock) begin
        if (start_trigger) begin
            field     <= start_field;
            last_line <= (scan_mode == mode_line_doubled) ? 9'(`FIELD_LINES - 1)
                                                          : 9'(`V_END_PROG - 1);
        end
    end

    assign rd_addr = `ADDR_W'((line_count % `BUFFER_LINES) * `LINE_SLOT + period_count);

    // Tags travel beside the RAM read so consecutive reads overlap
    always_ff @(posedge clock) begin
        if (reset) begin
            tag_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            tag_valid <= rd_en;
            out_valid <= tag_valid;
        end
    end

    always_ff @(posedge clock) begin
        tag_x     <= period_count;
        tag_line  <= line_count;
        tag_field <= field;
        out_pixel <= rd_data;
        out_x     <= tag_x;
        out_line  <= tag_line;
        out_field <= tag_field;
    end

    no_read_when_idle: assert property (
        @(posedge clock) disable iff (reset)
        state == rd_idle |-> !rd_en
    );

    out_x_in_range: assert property (
        @(posedge clock) disable iff (reset)
        out_valid |-> out_x < 10'(`CAPTURE_WIDTH)
    );

endmodule

// ==== capture_top.sv ====
`timescale 1ns/100ps

`include "capture_settings.svh"

module capture_top
    import capture_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic [23:0] pixel,
    input  logic        line_start,
    input  logic        frame_start,
    input  scan_mode_t  scan_mode,
    output logic        out_valid,
    output logic [23:0] out_pixel,
    output logic [9:0]  out_x,
    output logic [8:0]  out_line,
    output logic        out_field
);

    logic [`COORD_W-1:0] counter_x;
    logic [`COORD_W-1:0] counter_y;
    logic [23:0]         pixel_d;

    logic                wr_en;
    logic [`ADDR_W-1:0]  wr_addr;
    logic [23:0]         wr_data;
    logic                start_trigger;
    logic                start_field;

    logic                rd_en;
    logic [`ADDR_W-1:0]  rd_addr;
    logic [23:0]         rd_data;

    video_counters u_counters (
        .clock       (clock),
        .reset       (reset),
        .line_start  (line_start),
        .frame_start (frame_start),
        .pixel       (pixel),
        .counter_x   (counter_x),
        .counter_y   (counter_y),
        .pixel_d     (pixel_d)
    );

    video2ram u_capture (
        .clock         (clock),
        .reset         (reset),
        .scan_mode     (scan_mode),
        .pixel_d       (pixel_d),
        .counter_x     (counter_x),
        .counter_y     (counter_y),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .start_trigger (start_trigger),
        .start_field   (start_field)
    );

    line_buffer_ram u_ram (
        .clock   (clock),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    line_reader u_reader (
        .clock         (clock),
        .reset         (reset),
        .scan_mode     (scan_mode),
        .start_trigger (start_trigger),
        .start_field   (start_field),
        .rd_data       (rd_data),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .out_valid     (out_valid),
        .out_pixel     (out_pixel),
        .out_x         (out_x),
        .out_line      (out_line),
        .out_field     (out_field)
    );

endmodule

// ==== capture_tb_ref.svh ====
`ifndef CAPTURE_TB_REF_SVH
`define CAPTURE_TB_REF_SVH

// Fibonacci LFSR for x^8 + x^6 + x^5 + x^4 + 1, the new bit enters at bit 0
function automatic logic [7:0] lfsr_step(input logic [7:0] state);
    logic feedback;
    feedback = state[7] ^ state[5] ^ state[4] ^ state[3];
    return {state[6:0], feedback};
endfunction

// Source test pattern, the frame number sits in the top of the blue byte
function automatic logic [23:0] source_pixel(
    input logic [9:0] x,
    input logic [9:0] y,
    input logic [3:0] frame
);
    return {x[7:0], y[7:0], frame, x[9:8], y[9:8]};
endfunction

// Maps an output back to the source pixel it was captured from
function automatic logic [23:0] expected_pixel(
    input scan_mode_t mode,
    input logic       field,
    input int         run_line,
    input int         column,
    input int         frame
);
    int src_x;
    int src_y;
    src_y = field ? run_line + `FIELD2_FIRST : run_line;
    if (mode == mode_line_doubled) begin
        src_x = column + `H_START_DBL;
    end else begin
        src_x = column + `H_START_PROG;
    end
    return source_pixel(10'(src_x), 10'(src_y), 4'(frame));
endfunction

// Output n of a frame in readout order, split into field, run line and column
task automatic readout_position(
    input  scan_mode_t mode,
    input  int         n,
    output logic       field,
    output int         run_line,
    output int         column
);
    int line_idx;
    line_idx = n / `CAPTURE_WIDTH;
    column   = n % `CAPTURE_WIDTH;
    field    = 1'b0;
    run_line = line_idx;
    if (mode == mode_line_doubled && line_idx >= `FIELD_LINES) begin
        field    = 1'b1;
        run_line = line_idx - `FIELD_LINES;
    end
endtask

`endif

// ==== capture_tb.sv ====
`timescale 1ns/100ps

`include "capture_settings.svh"

module capture_tb
    import capture_pkg::*;
();

    localparam int frame_outputs = `V_END_PROG * `CAPTURE_WIDTH;
    localparam int frame_count   = 6;

    logic        clock;
    logic        reset;
    logic [23:0] pixel;
    logic        line_start;
    logic        frame_start;
    scan_mode_t  scan_mode;
    logic        out_valid;
    logic [23:0] out_pixel;
    logic [9:0]  out_x;
    logic [8:0]  out_line;
    logic        out_field;

    // Source position and frame bookkeeping that the monitor reads
    int          out_count;
    int          frame_base;
    int          cur_frame;
    scan_mode_t  cur_mode;
    logic        frame_active;
    int          src_y;
    logic [7:0]  lfsr;

    `include "capture_tb_ref.svh"

    capture_top u_dut (
        .clock       (clock),
        .reset       (reset),
        .pixel       (pixel),
        .line_start  (line_start),
        .frame_start (frame_start),
        .scan_mode   (scan_mode),
        .out_valid   (out_valid),
        .out_pixel   (out_pixel),
        .out_x       (out_x),
        .out_line    (out_line),
        .out_field   (out_field)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic stop_at_error();
        $display("Verification failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_pixel(input string name, input logic [23:0] exp_pixel,
                               input logic [23:0] act_pixel);
        if (act_pixel !== exp_pixel) begin
            $display("MISMATCH %s: expected pixel %h, actual %h", name, exp_pixel, act_pixel);
            stop_at_error();
        end
    endtask

    task automatic check_coord(input string name, input logic [9:0] exp_x,
                               input logic [9:0] act_x, input logic [8:0] exp_line,
                               input logic [8:0] act_line);
        if (act_x !== exp_x || act_line !== exp_line) begin
            $display("MISMATCH %s: expected x %0d line %0d, actual x %0d line %0d",
                     name, exp_x, exp_line, act_x, act_line);
            stop_at_error();
        end
    endtask

    task automatic check_mode_field(input string name, input scan_mode_t mode,
                                    input logic exp_field, input logic act_field);
        if (act_field !== exp_field) begin
            $display("MISMATCH %s: field in %s expected %0d, actual %0d",
                     name, mode.name(), exp_field, act_field);
            stop_at_error();
        end
    endtask

    task automatic check_count(input string name, input int exp_count, input int act_count);
        if (act_count != exp_count) begin
            $display("MISMATCH %s: expected %0d outputs, actual %0d",
                     name, exp_count, act_count);
            stop_at_error();
        end
    endtask

    task automatic compare_output();
        logic  exp_field;
        int    exp_line;
        int    exp_x;
        string name;
        if (reset || !frame_active || src_y == 0) begin
            $display("out_valid was raised before any readout trigger");
            stop_at_error();
        end else if (out_count - frame_base >= frame_outputs) begin
            $display("Frame %0d produced more than %0d outputs", cur_frame, frame_outputs);
            stop_at_error();
        end else begin
            readout_position(cur_mode, out_count - frame_base, exp_field, exp_line, exp_x);
            name = $sformatf("frame %0d %s", cur_frame, cur_mode.name());
            check_mode_field(name, cur_mode, exp_field, out_field);
            check_coord(name, 10'(exp_x), out_x, 9'(exp_line), out_line);
            check_pixel(name, expected_pixel(cur_mode, exp_field, exp_line, exp_x, cur_frame),
                        out_pixel);
            out_count = out_count + 1;
        end
    endtask

    // Outputs change on the rising edge and are stable at the falling one
    always @(negedge clock) begin
        if (out_valid) begin
            compare_output();
        end
    end

    task automatic drive_frame(input int frame, input scan_mode_t mode);
        for (int y = 0; y < `V_TOTAL; y++) begin
            for (int x = 0; x < `H_TOTAL; x++) begin
                @(posedge clock);
                #1;
                line_start  = (x == 0);
                frame_start = (x == 0 && y == 0);
                if (x == 0 && y == 0) begin
                    if (frame > 0) begin
                        check_count($sformatf("frame %0d output count", frame - 1),
                                    frame_outputs, out_count - frame_base);
                    end
                    frame_base   = out_count;
                    scan_mode    = mode;
                    cur_mode     = mode;
                    cur_frame    = frame;
                    frame_active = 1'b1;
                end
                src_y = y;
                pixel = source_pixel(10'(x), 10'(y), 4'(frame));
            end
        end
    endtask

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (out_count - frame_base < frame_outputs && cycles < 2 * `H_TOTAL) begin
            @(posedge clock);
            cycles++;
        end
        if (out_count - frame_base < frame_outputs) begin
            $display("Timed out waiting for the readout of the last frame");
            stop_at_error();
        end
    endtask

    initial begin
        scan_mode_t mode;
        out_count    = 0;
        frame_base   = 0;
        cur_frame    = 0;
        cur_mode     = mode_progressive;
        frame_active = 1'b0;
        src_y        = 0;
        lfsr         = 8'd42;
        reset        = 1'b1;
        pixel        = '0;
        line_start   = 1'b0;
        frame_start  = 1'b0;
        scan_mode    = mode_progressive;
        for (int c = 0; c < 5; c++) begin
            @(posedge clock);
            #1;
            if (out_valid !== 1'b0) begin
                $display("out_valid is not low during reset");
                stop_at_error();
            end
        end
        reset = 1'b0;
        for (int c = 0; c < 8; c++) begin
            @(posedge clock);
        end
        // One LFSR bit per frame picks its scan mode
        for (int f = 0; f < frame_count; f++) begin
            lfsr = lfsr_step(lfsr);
            mode = lfsr[0] ? mode_line_doubled : mode_progressive;
            drive_frame(f, mode);
        end
        wait_for_drain();
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+.
capture_pkg.sv
video_counters.sv
video2ram.sv
line_buffer_ram.sv
line_reader.sv
capture_top.sv
capture_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert --top-module capture_tb -f build.f \
        -o capture_sim &&
    ./obj_dir/capture_sim ||
    { echo "Simulation did not pass" >&2; exit 1; }
